// File: ila_uart.f
hdl/ila_pkg.sv
hdl/uart_link.sv
hdl/trigger_compare.sv
hdl/capture_buffer.sv
hdl/ila_command_fsm.sv
hdl/ila_uart_top.sv
verification/tb_clock_gen.sv
verification/ila_uart_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module ila_uart_tb \
	-f ila_uart.f --Mdir obj_dir -o ila_uart_sim
./obj_dir/ila_uart_sim > sim.log 2>&1
cat sim.log

if grep -q "=== FAIL ===" sim.log || ! grep -q "=== PASS ===" sim.log; then
	echo "simulation reported failure, see sim.log"
	exit 1
fi

// File: verification/ila_uart_tb.sv
`timescale 1ns/1ps

module ila_uart_tb;

	import ila_pkg::*;

	localparam int         CHANNELS      = 2;
	localparam int         CHANNEL_WIDTH = 8;
	localparam int         DEPTH         = 16;
	localparam int         CLKDIV        = 8;		// Clocks per serial bit
	localparam int         ROW_BYTES     = CHANNELS * CHANNEL_WIDTH / 8;
	localparam int         GAP_CYCLES    = 12 * CLKDIV;	// Quiet line after each test
	localparam logic [7:0] TRIG_TARGET   = 8'h80;
	localparam logic [7:0] TRIG_OFFSET   = 8'h05;
	localparam logic [7:0] CH1_XOR       = 8'h5a;
	localparam logic [7:0] MODE_EQUAL    = {6'd0, COMPARE_EQUAL};

	// How a waveform reply is judged
	localparam int ROWS_NONE        = 0;
	localparam int ROWS_TRIGGER     = 1;
	localparam int ROWS_CONSECUTIVE = 2;

	typedef struct packed {
		logic [2:0]      n_cmd;
		logic [3:0][7:0] cmd;			// Left aligned with the first byte in [3]
		logic [5:0]      n_reply;
		logic [2:0][7:0] reply;		// Left aligned fixed reply bytes
		logic [1:0]      rows;
		logic            align;			// Start once channel 0 reads 00
		logic [11:0]     wait_cycles;	// Idle time before the command
	} test_entry_t;

	logic                                   clk;
	logic                                   reset;
	logic [CHANNELS-1:0][CHANNEL_WIDTH-1:0] probe_in = {CH1_XOR, 8'h00};
	logic [15:0]                            clkdiv   = 16'(CLKDIV);
	logic                                   uart_rxd;
	logic                                   uart_txd;

	test_entry_t tests[$];
	string       test_names[$];
	logic [7:0]  rx_q[$];			// Bytes seen on uart_txd
	int          errors      = 0;
	int          checks      = 0;
	int          cycles      = 0;
	int          cycle_limit = 0;

	tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(5)) clkgen0 (.clk(clk), .reset(reset));

	ila_uart_top #(
		.CHANNELS      (CHANNELS),
		.CHANNEL_WIDTH (CHANNEL_WIDTH),
		.DEPTH         (DEPTH)
	) dut0 (
		.clk      (clk),
		.reset    (reset),
		.probe_in (probe_in),
		.clkdiv   (clkdiv),
		.uart_rxd (uart_rxd),
		.uart_txd (uart_txd)
	);

	////////////////////////////////////////
	// Probe stimulus and run limit

	always @(negedge clk) begin
		clkdiv      <= 16'(CLKDIV);
		probe_in[0] <= probe_in[0] + 8'd1;				// Free running count
		probe_in[1] <= (probe_in[0] + 8'd1) ^ CH1_XOR;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout: the tests did not finish within %0d clock cycles", cycle_limit);
			$display("=== FAIL ===");
			$finish;
		end
	end

	////////////////////////////////////////
	// Host side of the serial line

	// Sampled mid-bit on falling edges
	initial begin : collect_replies
		logic [7:0] data;
		wait (reset === 1'b0);
		forever begin
			@(negedge clk);
			if (uart_txd === 1'b0) begin
				repeat (CLKDIV / 2) @(negedge clk);		// Middle of start bit
				if (uart_txd !== 1'b0) begin
					$display("Framing error: start bit on uart_txd ended early");
					errors++;
				end else begin
					for (int i = 0; i < 8; i++) begin
						repeat (CLKDIV) @(negedge clk);
						data[i] = uart_txd;				// LSB first
					end
					repeat (CLKDIV) @(negedge clk);
					if (uart_txd !== 1'b1) begin
						$display("Framing error: stop bit on uart_txd was low");
						errors++;
					end
					rx_q.push_back(data);
				end
			end
		end
	end

	task automatic send_byte(input logic [7:0] value);
		logic [9:0] frame;
		frame = {1'b1, value, 1'b0};	// Stop, data, start
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			uart_rxd = frame[i];
			repeat (CLKDIV - 1) @(negedge clk);
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			$display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	////////////////////////////////////////
	// Test table

	task automatic add_test(input string name, input int n_cmd, input logic [31:0] cmd,
			input int n_reply, input logic [23:0] reply, input int rows,
			input bit align, input int wait_cycles);
		test_entry_t t;
		t.n_cmd       = 3'(n_cmd);
		t.cmd         = cmd;
		t.n_reply     = 6'(n_reply);
		t.reply       = reply;
		t.rows        = 2'(rows);
		t.align       = align;
		t.wait_cycles = 12'(wait_cycles);
		tests.push_back(t);
		test_names.push_back(name);
	endtask

	task automatic run_test(input int idx);
		test_entry_t t;
		string       name;
		logic [7:0]  ch0;
		logic [7:0]  ch1;
		logic [7:0]  prev;
		logic [7:0]  expect_ch0;
		int          err_before;
		t          = tests[idx];
		name       = test_names[idx];
		err_before = errors;
		prev       = 8'h00;
		repeat (t.wait_cycles) @(negedge clk);
		if (t.align)
			while (probe_in[0] !== 8'h00) @(posedge clk);	// Known counter phase
		rx_q.delete();
		for (int i = 0; i < t.n_cmd; i++)
			send_byte(t.cmd[3 - i]);
		while (rx_q.size() < int'(t.n_reply)) @(negedge clk);

		if (t.rows == ROWS_NONE) begin
			for (int i = 0; i < t.n_reply; i++)
				check_value(name, t.reply[2 - i], rx_q[i]);
		end else begin
			for (int k = 0; k < DEPTH; k++) begin
				ch0 = rx_q[k * ROW_BYTES];		// Channel 0 comes first
				ch1 = rx_q[k * ROW_BYTES + 1];
				if (t.rows == ROWS_TRIGGER) begin
					// Trigger sample sits in row TRIG_OFFSET
					expect_ch0 = 8'(TRIG_TARGET - TRIG_OFFSET + 8'(k));
					check_value(name, expect_ch0, ch0);
					check_value(name, expect_ch0 ^ CH1_XOR, ch1);
				end else begin
					check_value(name, ch0 ^ CH1_XOR, ch1);
					if (k > 0)
						check_value(name, 8'(prev + 8'd1), ch0);	// One sample per clock
				end
				prev = ch0;
			end
		end

		repeat (GAP_CYCLES) @(negedge clk);
		if (rx_q.size() != int'(t.n_reply)) begin
			$display("Test %s got %0d reply bytes where %0d were due",
				name, rx_q.size(), t.n_reply);
			errors++;
		end
		if (errors == err_before)
			$display("test %0d %s: ok", idx, name);
		else
			$display("test %0d %s: %0d errors", idx, name, errors - err_before);
	endtask

	////////////////////////////////////////
	// Main sequence

	initial begin : main
		int total;
		uart_rxd = 1'b1;

		add_test("channel count", 1, {CMD_GET_CHANNEL_COUNT, 24'h0}, 1, 24'h02_0000,
			ROWS_NONE, 0, 0);
		add_test("depth", 1, {CMD_GET_DEPTH, 24'h0}, 3, 24'h00_0010, ROWS_NONE, 0, 0);
		add_test("nop and unknown opcode", 2, {CMD_NOP, 8'hff, 16'h0}, 0, 24'h0,
			ROWS_NONE, 0, 0);
		add_test("status after reset", 1, {CMD_GET_STATUS, 24'h0}, 1, 24'h00_0000,
			ROWS_NONE, 0, 0);
		add_test("arm", 1, {CMD_ARM, 24'h0}, 0, 24'h0, ROWS_NONE, 0, 0);
		add_test("status armed", 1, {CMD_GET_STATUS, 24'h0}, 1, 24'h01_0000, ROWS_NONE, 0, 0);
		add_test("stop", 1, {CMD_STOP, 24'h0}, 0, 24'h0, ROWS_NONE, 0, 0);
		add_test("status stopped", 1, {CMD_GET_STATUS, 24'h0}, 1, 24'h00_0000,
			ROWS_NONE, 0, 0);

		// Compare trigger in OR mode
		add_test("trigger offset", 3, {CMD_SET_TRIG_OFFSET, 8'h00, TRIG_OFFSET, 8'h00},
			0, 24'h0, ROWS_NONE, 0, 0);
		add_test("channel 0 equal", 3, {CMD_SET_TRIG_MODE, 8'h00, MODE_EQUAL, 8'h00},
			0, 24'h0, ROWS_NONE, 0, 0);
		add_test("channel 0 target", 3, {CMD_SET_COMPARE_TARGET, 8'h00, TRIG_TARGET, 8'h00},
			0, 24'h0, ROWS_NONE, 0, 0);
		add_test("arm for compare", 1, {CMD_ARM, 24'h0}, 0, 24'h0, ROWS_NONE, 1, 0);
		add_test("status compare triggered", 1, {CMD_GET_STATUS, 24'h0}, 1, 24'h07_0000,
			ROWS_NONE, 0, 300);
		add_test("data compare triggered", 1, {CMD_GET_DATA, 24'h0}, DEPTH * ROW_BYTES, 24'h0,
			ROWS_TRIGGER, 0, 0);
		add_test("status after readback", 1, {CMD_GET_STATUS, 24'h0}, 1, 24'h06_0000,
			ROWS_NONE, 0, 0);

		// Match-all never met until FORCE
		add_test("match all on", 2, {CMD_SET_MATCH_ALL, 8'h01, 16'h0}, 0, 24'h0,
			ROWS_NONE, 0, 0);
		add_test("channel 1 equal", 3, {CMD_SET_TRIG_MODE, 8'h01, MODE_EQUAL, 8'h00},
			0, 24'h0, ROWS_NONE, 0, 0);
		add_test("channel 0 target 10", 3, {CMD_SET_COMPARE_TARGET, 8'h00, 8'h10, 8'h00},
			0, 24'h0, ROWS_NONE, 0, 0);
		add_test("channel 1 target 10", 3, {CMD_SET_COMPARE_TARGET, 8'h01, 8'h10, 8'h00},
			0, 24'h0, ROWS_NONE, 0, 0);
		add_test("arm for match all", 1, {CMD_ARM, 24'h0}, 0, 24'h0, ROWS_NONE, 0, 0);
		add_test("status match all blocked", 1, {CMD_GET_STATUS, 24'h0}, 1, 24'h01_0000,
			ROWS_NONE, 0, 600);
		add_test("force", 1, {CMD_FORCE, 24'h0}, 0, 24'h0, ROWS_NONE, 0, 0);
		add_test("status after force", 1, {CMD_GET_STATUS, 24'h0}, 1, 24'h07_0000,
			ROWS_NONE, 0, 0);
		add_test("data after force", 1, {CMD_GET_DATA, 24'h0}, DEPTH * ROW_BYTES, 24'h0,
			ROWS_CONSECUTIVE, 0, 0);
		add_test("status after forced readback", 1, {CMD_GET_STATUS, 24'h0}, 1, 24'h06_0000,
			ROWS_NONE, 0, 0);

		// Serial time of every byte plus idle time and margin
		total = 2000;
		foreach (tests[i])
			total += (tests[i].n_cmd + tests[i].n_reply) * 10 * CLKDIV
				+ tests[i].wait_cycles + (tests[i].align ? 256 : 0) + GAP_CYCLES;
		cycle_limit = total;

		wait (reset === 1'b0);
		repeat (4) @(negedge clk);
		for (int i = 0; i < tests.size(); i++)
			run_test(i);

		$display("Summary: %0d tests, %0d checks, %0d errors", tests.size(), checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD       = 40,	// ns
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Released on a falling edge, away from the sampling edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

// File: hdl/ila_uart_top.sv
`timescale 1ns/1ps

module ila_uart_top #(
	parameter int  CHANNELS      = 2,	// At most 255
	parameter int  CHANNEL_WIDTH = 8,	// Multiple of 8
	parameter int  DEPTH         = 16,	// Power of two
	localparam int ADDR_BITS     = $clog2(DEPTH),
	localparam int ROW_BITS      = CHANNELS * CHANNEL_WIDTH
) (
	input  logic                                    clk,
	input  logic                                    reset,
	input  logic [CHANNELS-1:0][CHANNEL_WIDTH-1:0]  probe_in,
	input  logic [15:0]                             clkdiv,
	input  logic                                    uart_rxd,
	output logic                                    uart_txd
);

	import ila_pkg::*;

	////////////////////////////////////////
	// Interconnect

	logic                                   rx_valid;
	logic [7:0]                             rx_data;
	logic                                   tx_start;
	logic [7:0]                             tx_data;
	logic                                   tx_busy;
	logic                                   tx_done;

	logic                                   match_all;
	logic [ADDR_BITS-1:0]                   trig_offset;
	ila_compare_e [CHANNELS-1:0]            modes;
	logic [CHANNELS-1:0][CHANNEL_WIDTH-1:0] targets;
	logic                                   hit;		// Registered trigger
	capture_ctrl_t                          ctrl;
	ila_status_t                            status;

	logic                                   rd_en;
	logic [ADDR_BITS-1:0]                   rd_addr;
	logic [ROW_BITS-1:0]                    rd_data;

	////////////////////////////////////////
	// Serial line and command decoder

	uart_link uart0 (
		.clk      (clk),
		.reset    (reset),
		.clkdiv   (clkdiv),
		.rxd      (uart_rxd),
		.txd      (uart_txd),
		.rx_valid (rx_valid),
		.rx_data  (rx_data),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.tx_busy  (tx_busy),
		.tx_done  (tx_done)
	);

	ila_command_fsm #(
		.CHANNELS      (CHANNELS),
		.CHANNEL_WIDTH (CHANNEL_WIDTH),
		.DEPTH         (DEPTH)
	) cmd0 (
		.clk         (clk),
		.reset       (reset),
		.rx_valid    (rx_valid),
		.rx_data     (rx_data),
		.tx_start    (tx_start),
		.tx_data     (tx_data),
		.tx_busy     (tx_busy),
		.tx_done     (tx_done),
		.match_all   (match_all),
		.trig_offset (trig_offset),
		.modes       (modes),
		.targets     (targets),
		.ctrl        (ctrl),
		.status      (status),
		.rd_en       (rd_en),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data)
	);

	////////////////////////////////////////
	// Analyzer core

	trigger_compare #(
		.CHANNELS      (CHANNELS),
		.CHANNEL_WIDTH (CHANNEL_WIDTH)
	) trig0 (
		.clk       (clk),
		.reset     (reset),
		.probe_in  (probe_in),
		.modes     (modes),
		.targets   (targets),
		.match_all (match_all),
		.hit       (hit)
	);

	capture_buffer #(
		.CHANNELS      (CHANNELS),
		.CHANNEL_WIDTH (CHANNEL_WIDTH),
		.DEPTH         (DEPTH)
	) cap0 (
		.clk         (clk),
		.reset       (reset),
		.probe_in    (probe_in),
		.hit         (hit),
		.ctrl        (ctrl),
		.trig_offset (trig_offset),
		.rd_en       (rd_en),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.status      (status)
	);

endmodule

// File: hdl/ila_command_fsm.sv
`timescale 1ns/1ps

module ila_command_fsm #(
	parameter int  CHANNELS      = 2,
	parameter int  CHANNEL_WIDTH = 8,
	parameter int  DEPTH         = 16,
	localparam int ADDR_BITS     = $clog2(DEPTH),
	localparam int ROW_BITS      = CHANNELS * CHANNEL_WIDTH
) (
	input  logic                                    clk,
	input  logic                                    reset,
	input  logic                                    rx_valid,
	input  logic [7:0]                              rx_data,
	output logic                                    tx_start,
	output logic [7:0]                              tx_data,
	input  logic                                    tx_busy,
	input  logic                                    tx_done,
	output logic                                    match_all,
	output logic [ADDR_BITS-1:0]                    trig_offset,
	output ila_pkg::ila_compare_e [CHANNELS-1:0]    modes,
	output logic [CHANNELS-1:0][CHANNEL_WIDTH-1:0]  targets,
	output ila_pkg::capture_ctrl_t                  ctrl,
	input  ila_pkg::ila_status_t                    status,
	output logic                                    rd_en,
	output logic [ADDR_BITS-1:0]                    rd_addr,
	input  logic [ROW_BITS-1:0]                     rd_data
);

	import ila_pkg::*;

	localparam int          TARGET_BYTES = CHANNEL_WIDTH / 8;
	localparam int          ROW_BYTES    = ROW_BITS / 8;
	localparam logic [23:0] DEPTH_BYTES  = 24'(DEPTH);

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_MATCH_ALL,		// Argument collection
		ST_OFFSET_HI,
		ST_OFFSET_LO,
		ST_MODE_CHAN,
		ST_MODE_VAL,
		ST_TARGET_CHAN,
		ST_TARGET_BYTES,
		ST_TX_HOLD,			// Last reply byte in flight
		ST_DEPTH,
		ST_ROW_WAIT,		// Row streaming
		ST_ROW_SEND,
		ST_ROW_NEXT
	} state_e;

	state_e      state;
	logic [7:0]  cur_channel;	// Channel named by the first argument
	logic [7:0]  offset_hi;
	logic [15:0] byte_cnt;		// Byte within target, depth or row

	always_ff @(posedge clk) begin
		tx_start <= 1'b0;
		rd_en    <= 1'b0;
		ctrl     <= '0;
		if (reset) begin
			state       <= ST_IDLE;
			match_all   <= 1'b0;
			trig_offset <= '0;
			rd_addr     <= '0;
			byte_cnt    <= 16'd0;
			for (int i = 0; i < CHANNELS; i++)
				modes[i] <= COMPARE_NEVER;
		end else begin
			case (state)

				////////////////////////////////////////
				// Opcode decode

				ST_IDLE: begin
					byte_cnt <= 16'd0;
					if (rx_valid) begin
						case (ila_cmd_e'(rx_data))
							CMD_SET_MATCH_ALL:      state <= ST_MATCH_ALL;
							CMD_SET_TRIG_OFFSET:    state <= ST_OFFSET_HI;
							CMD_SET_TRIG_MODE:      state <= ST_MODE_CHAN;
							CMD_SET_COMPARE_TARGET: state <= ST_TARGET_CHAN;
							CMD_ARM:                ctrl.arm <= 1'b1;
							CMD_STOP:               ctrl.stop <= 1'b1;
							CMD_FORCE:              ctrl.trig_force <= 1'b1;
							CMD_GET_STATUS: begin
								tx_start <= 1'b1;	// Line is idle between commands
								tx_data  <= status;
								state    <= ST_TX_HOLD;
							end
							CMD_GET_CHANNEL_COUNT: begin
								tx_start <= 1'b1;
								tx_data  <= 8'(CHANNELS);
								state    <= ST_TX_HOLD;
							end
							CMD_GET_DEPTH: begin
								tx_start <= 1'b1;
								tx_data  <= DEPTH_BYTES[23:16];	// MSB first
								state    <= ST_DEPTH;
							end
							CMD_GET_DATA: begin
								rd_en   <= 1'b1;
								rd_addr <= '0;
								state   <= ST_ROW_WAIT;
							end
							default: ;	// NOP and unknown opcodes
						endcase
					end
				end

				////////////////////////////////////////
				// Configuration arguments

				ST_MATCH_ALL: begin
					if (rx_valid) begin
						match_all <= rx_data[0];
						state     <= ST_IDLE;
					end
				end
				ST_OFFSET_HI: begin
					if (rx_valid) begin
						offset_hi <= rx_data;
						state     <= ST_OFFSET_LO;
					end
				end
				ST_OFFSET_LO: begin
					if (rx_valid) begin
						trig_offset <= ADDR_BITS'({offset_hi, rx_data});
						state       <= ST_IDLE;
					end
				end
				ST_MODE_CHAN: begin
					if (rx_valid) begin
						cur_channel <= rx_data;
						state       <= ST_MODE_VAL;
					end
				end
				ST_MODE_VAL: begin
					if (rx_valid) begin
						if (cur_channel < CHANNELS)	// Out of range channel ignored
							modes[cur_channel] <= ila_compare_e'(rx_data[1:0]);
						state <= ST_IDLE;
					end
				end
				ST_TARGET_CHAN: begin
					if (rx_valid) begin
						cur_channel <= rx_data;
						byte_cnt    <= 16'(TARGET_BYTES - 1);	// Big endian, count down
						state       <= ST_TARGET_BYTES;
					end
				end
				ST_TARGET_BYTES: begin
					if (rx_valid) begin
						if (cur_channel < CHANNELS)
							targets[cur_channel][byte_cnt*8 +: 8] <= rx_data;
						byte_cnt <= byte_cnt - 16'd1;
						if (byte_cnt == 16'd0)
							state <= ST_IDLE;
					end
				end

				////////////////////////////////////////
				// Replies

				ST_TX_HOLD: begin
					if (tx_done)
						state <= ST_IDLE;
				end
				ST_DEPTH: begin
					if (tx_done) begin
						tx_start <= 1'b1;
						byte_cnt <= byte_cnt + 16'd1;
						if (byte_cnt == 16'd0)
							tx_data <= DEPTH_BYTES[15:8];
						else begin
							tx_data <= DEPTH_BYTES[7:0];
							state   <= ST_TX_HOLD;
						end
					end
				end

				// rd_data lands at the end of this cycle
				ST_ROW_WAIT: state <= ST_ROW_SEND;

				ST_ROW_SEND: begin
					// First byte of a row needs a free line, the rest follow tx_done
					if ((byte_cnt == 16'd0 && !tx_busy) || tx_done) begin
						tx_start <= 1'b1;
						tx_data  <= rd_data[byte_cnt*8 +: 8];	// Channel 0 low byte first
						byte_cnt <= byte_cnt + 16'd1;
						if (byte_cnt == 16'(ROW_BYTES - 1)) begin
							byte_cnt <= 16'd0;
							if (&rd_addr) begin
								ctrl.stop <= 1'b1;	// Readback complete, disarm
								state     <= ST_TX_HOLD;
							end else
								state <= ST_ROW_NEXT;
						end
					end
				end
				ST_ROW_NEXT: begin
					if (tx_done) begin	// Last byte of previous row out
						rd_en   <= 1'b1;
						rd_addr <= rd_addr + 1'b1;
						state   <= ST_ROW_WAIT;
					end
				end

				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// File: hdl/capture_buffer.sv
`timescale 1ns/1ps

module capture_buffer #(
	parameter int  CHANNELS      = 2,
	parameter int  CHANNEL_WIDTH = 8,
	parameter int  DEPTH         = 16,
	localparam int ADDR_BITS     = $clog2(DEPTH),
	localparam int ROW_BITS      = CHANNELS * CHANNEL_WIDTH
) (
	input  logic                                    clk,
	input  logic                                    reset,
	input  logic [CHANNELS-1:0][CHANNEL_WIDTH-1:0]  probe_in,
	input  logic                                    hit,
	input  ila_pkg::capture_ctrl_t                  ctrl,
	input  logic [ADDR_BITS-1:0]                    trig_offset,	// Pre-trigger rows
	input  logic                                    rd_en,
	input  logic [ADDR_BITS-1:0]                    rd_addr,		// Row 0 is oldest
	output logic [ROW_BITS-1:0]                     rd_data,
	output ila_pkg::ila_status_t                    status
);

	logic [ROW_BITS-1:0]  mem [DEPTH];		// Circular sample memory
	logic [ROW_BITS-1:0]  probe_q;			// Lines up with registered hit
	logic [ADDR_BITS-1:0] wr_ptr;			// Next row to write, oldest once done
	logic [ADDR_BITS-1:0] post_left;		// Samples still owed after trigger
	logic [ADDR_BITS-1:0] post_total;
	logic [ADDR_BITS-1:0] rd_phys;
	logic                 capturing;
	logic                 trig_now;

	assign capturing  = status.armed && !status.done;
	assign trig_now   = status.armed && !status.triggered && (hit || ctrl.trig_force);
	assign post_total = ADDR_BITS'(DEPTH - 1) - trig_offset;
	assign rd_phys    = wr_ptr + rd_addr;	// Wraps with DEPTH a power of two

	////////////////////////////////////////
	// Arm, trigger and post-trigger count

	always_ff @(posedge clk) begin
		if (reset) begin
			status    <= '0;
			wr_ptr    <= '0;
			post_left <= '0;
		end else begin
			if (capturing)
				wr_ptr <= wr_ptr + 1'b1;

			if (ctrl.arm) begin
				status.armed     <= 1'b1;
				status.triggered <= 1'b0;
				status.done      <= 1'b0;
			end else if (ctrl.stop)
				status.armed <= 1'b0;
			else if (trig_now) begin
				status.triggered <= 1'b1;
				post_left        <= post_total;
				if (post_total == '0)
					status.done <= 1'b1;	// Trigger sample is the last one
			end else if (capturing && status.triggered) begin
				post_left <= post_left - 1'b1;
				if (post_left == ADDR_BITS'(1))
					status.done <= 1'b1;	// Memory frozen from here
			end
		end
	end

	////////////////////////////////////////
	// Sample memory

	always_ff @(posedge clk) begin
		probe_q <= probe_in;
		if (capturing)
			mem[wr_ptr] <= probe_q;
		if (rd_en)
			rd_data <= mem[rd_phys];	// Held until next read
	end

endmodule

// File: hdl/trigger_compare.sv
`timescale 1ns/1ps

module trigger_compare #(
	parameter int CHANNELS      = 2,
	parameter int CHANNEL_WIDTH = 8
) (
	input  logic                                    clk,
	input  logic                                    reset,
	input  logic [CHANNELS-1:0][CHANNEL_WIDTH-1:0]  probe_in,
	input  ila_pkg::ila_compare_e [CHANNELS-1:0]    modes,
	input  logic [CHANNELS-1:0][CHANNEL_WIDTH-1:0]  targets,
	input  logic                                    match_all,	// AND instead of OR
	output logic                                    hit
);

	import ila_pkg::*;

	logic [CHANNELS-1:0] chan_hit;		// Per-channel result
	logic [CHANNELS-1:0] chan_used;		// Mode other than NEVER
	logic                any_hit;
	logic                all_hit;

	////////////////////////////////////////
	// Per-channel comparators

	always_comb begin
		for (int i = 0; i < CHANNELS; i++) begin
			case (modes[i])
				COMPARE_EQUAL:     chan_hit[i] = probe_in[i] == targets[i];
				COMPARE_NOT_EQUAL: chan_hit[i] = probe_in[i] != targets[i];
				COMPARE_ALWAYS:    chan_hit[i] = 1'b1;
				default:           chan_hit[i] = 1'b0;
			endcase
			chan_used[i] = modes[i] != COMPARE_NEVER;
		end
	end

	////////////////////////////////////////
	// Combiner

	assign any_hit = |chan_hit;
	// NEVER channels drop out of AND, but all NEVER means no trigger
	assign all_hit = (|chan_used) && (chan_hit == chan_used);

	always_ff @(posedge clk) begin
		if (reset)
			hit <= 1'b0;
		else
			hit <= match_all ? all_hit : any_hit;	// One cycle behind probe_in
	end

endmodule

// File: hdl/uart_link.sv
`timescale 1ns/1ps

module uart_link (
	input  logic        clk,
	input  logic        reset,
	input  logic [15:0] clkdiv,		// Clocks per bit, both directions
	input  logic        rxd,
	output logic        txd,
	output logic        rx_valid,
	output logic [7:0]  rx_data,
	input  logic        tx_start,
	input  logic [7:0]  tx_data,
	output logic        tx_busy,
	output logic        tx_done
);

	////////////////////////////////////////
	// Receiver

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,	// Waiting for middle of start bit
		RX_DATA,
		RX_STOP
	} rx_state_e;

	rx_state_e   rx_state;
	logic [1:0]  rxd_sync;		// Two-flop synchronizer
	logic        rx_line;
	logic [15:0] rx_count;		// Cycles left until next sample point
	logic [2:0]  rx_bits;		// Data bits taken so far
	logic [7:0]  rx_shift;		// LSB arrives first

	assign rx_line = rxd_sync[1];
	assign rx_data = rx_shift;

	always_ff @(posedge clk) begin
		if (reset)
			rxd_sync <= 2'b11;	// Line idles high
		else
			rxd_sync <= {rxd_sync[0], rxd};
	end

	always_ff @(posedge clk) begin
		rx_valid <= 1'b0;
		if (reset) begin
			rx_state <= RX_IDLE;
			rx_count <= 16'd0;
			rx_bits  <= 3'd0;
		end else begin
			case (rx_state)
				RX_IDLE: begin
					if (!rx_line) begin	// Falling edge of start bit
						rx_count <= {1'b0, clkdiv[15:1]};	// Half a bit
						rx_state <= RX_START;
					end
				end
				RX_START: begin
					if (rx_count != 16'd0)
						rx_count <= rx_count - 16'd1;
					else if (rx_line)
						rx_state <= RX_IDLE;	// Glitch, not a real start bit
					else begin
						rx_count <= clkdiv - 16'd1;
						rx_bits  <= 3'd0;
						rx_state <= RX_DATA;
					end
				end
				RX_DATA: begin
					if (rx_count != 16'd0)
						rx_count <= rx_count - 16'd1;
					else begin
						rx_shift <= {rx_line, rx_shift[7:1]};
						rx_count <= clkdiv - 16'd1;
						rx_bits  <= rx_bits + 3'd1;
						if (rx_bits == 3'd7)
							rx_state <= RX_STOP;
					end
				end
				default: begin	// RX_STOP
					if (rx_count != 16'd0)
						rx_count <= rx_count - 16'd1;
					else begin
						rx_valid <= rx_line;	// Drop frames with a bad stop bit
						rx_state <= RX_IDLE;
					end
				end
			endcase
		end
	end

	////////////////////////////////////////
	// Transmitter

	logic [8:0]  tx_shift;		// Remaining data bits plus stop bit
	logic [3:0]  tx_bits;		// 0 is start, 9 is stop
	logic [15:0] tx_count;

	always_ff @(posedge clk) begin
		tx_done <= 1'b0;
		if (reset) begin
			txd      <= 1'b1;
			tx_busy  <= 1'b0;
			tx_bits  <= 4'd0;
			tx_count <= 16'd0;
		end else if (!tx_busy) begin
			if (tx_start) begin
				tx_shift <= {1'b1, tx_data};
				txd      <= 1'b0;			// Start bit
				tx_busy  <= 1'b1;
				tx_bits  <= 4'd0;
				tx_count <= clkdiv - 16'd1;
			end
		end else if (tx_count != 16'd0)
			tx_count <= tx_count - 16'd1;
		else if (tx_bits == 4'd9) begin	// Stop bit finished
			tx_busy <= 1'b0;
			tx_done <= 1'b1;
		end else begin
			txd      <= tx_shift[0];
			tx_shift <= {1'b1, tx_shift[8:1]};
			tx_bits  <= tx_bits + 4'd1;
			tx_count <= clkdiv - 16'd1;
		end
	end

endmodule

// File: hdl/ila_pkg.sv
package ila_pkg;

	////////////////////////////////////////
	// Host command opcodes

	// One opcode byte, then any argument bytes big endian
	typedef enum logic [7:0] {
		CMD_NOP                = 8'h00,	// Ignored
		CMD_SET_MATCH_ALL      = 8'h01,	// 1 byte, bit 0 selects AND
		CMD_SET_TRIG_OFFSET    = 8'h02,	// 2 bytes, samples kept before trigger
		CMD_SET_TRIG_MODE      = 8'h03,	// Channel byte then mode byte
		CMD_SET_COMPARE_TARGET = 8'h04,	// Channel byte then target bytes
		CMD_ARM                = 8'h05,
		CMD_STOP               = 8'h06,
		CMD_FORCE              = 8'h07,	// Trigger now
		CMD_GET_STATUS         = 8'h08,	// 1 byte reply
		CMD_GET_CHANNEL_COUNT  = 8'h0a,	// 1 byte reply
		CMD_GET_DATA           = 8'h0d,	// DEPTH rows, oldest first
		CMD_GET_DEPTH          = 8'h0e	// 3 byte reply
	} ila_cmd_e;

	////////////////////////////////////////
	// Comparator modes

	// Low two bits of the mode byte
	typedef enum logic [1:0] {
		COMPARE_NEVER     = 2'd0,
		COMPARE_EQUAL     = 2'd1,
		COMPARE_NOT_EQUAL = 2'd2,
		COMPARE_ALWAYS    = 2'd3
	} ila_compare_e;

	////////////////////////////////////////
	// Status and control

	// Byte returned by GET_STATUS
	typedef struct packed {
		logic [4:0] reserved;	// Always zero
		logic       done;		// Post-trigger samples all written
		logic       triggered;
		logic       armed;
	} ila_status_t;

	// One-cycle pulses from the command decoder
	typedef struct packed {
		logic arm;
		logic stop;
		logic trig_force;
	} capture_ctrl_t;

endpackage
